/* Makefile */
# Verilator build and run for the floating-point divider

VERILATOR ?= verilator
TOP ?= tb_fpDivide
FILELIST ?= fpDivide.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q -- "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* fpDecompose.sv */
`timescale 1ns/1ps
`include "fpDiv_consts.svh"

module fpDecompose (
	input  logic clk,
	input  logic rst,
	input  logic ce,
	input  logic ld,
	input  fpDivPkg::fpWord a,
	input  fpDivPkg::fpWord b,
	input  logic done,
	output logic jobValid,
	output fpDivPkg::divJob job,
	output logic busy
);

	logic accept;

	// split a word and sort it into zero, inf, nan or normal
	function automatic fpDivPkg::fpClass classify(input fpDivPkg::fpWord w);
		fpDivPkg::fpClass c;
		logic expAllOnes;
		logic fracZero;
		expAllOnes = &w[`FP_WORD_W-2 -: `FP_EXP_W];
		fracZero = ~|w[`FP_FRAC_W-1:0];
		c.sign = w[`FP_WORD_W-1];
		c.exp = w[`FP_WORD_W-2 -: `FP_EXP_W];
		// exponent zero covers denormals too, they read as zero
		c.isZero = ~|c.exp;
		c.isInf = expAllOnes & fracZero;
		c.isNan = expAllOnes & ~fracZero;
		// zero gets an empty significand so the core divides nothing
		c.mant = c.isZero ? '0 : {1'b1, w[`FP_FRAC_W-1:0]};
		return c;
	endfunction

	// ---------------------------------------------------------------------------
	// accept
	// ---------------------------------------------------------------------------

	// new op only when the last result is out and nothing is pending
	assign accept = ld && done && !busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			jobValid <= 1'b0;
			busy <= 1'b0;
		end else if (ce) begin
			// single cycle strobe toward the core
			jobValid <= accept;
			// busy covers the cycle before the consumer drops done
			if (accept)
				busy <= 1'b1;
			else if (!done)
				busy <= 1'b0;
		end
	end

	// operand capture, payload only
	always_ff @(posedge clk) begin
		if (ce && accept) begin
			job.dividend <= classify(a);
			job.divisor <= classify(b);
		end
	end

endmodule

/* fpDivCore.sv */
`timescale 1ns/1ps
`include "fpDiv_consts.svh"

module fpDivCore (
	input  logic clk,
	input  logic rst,
	input  logic ce,
	input  logic jobValid,
	input  fpDivPkg::divJob job,
	output logic resValid,
	output fpDivPkg::coreResult res
);

	localparam int CNT_W = $clog2(`DIV_ITERS);
	// remainder stays below twice the divisor, two spare bits on top
	localparam int REM_W = `FP_FRAC_W + 3;

	fpDivPkg::coreState state;
	logic [CNT_W-1:0] iter;
	logic lastIter;

	// datapath registers
	logic [REM_W-1:0] rem;
	logic [REM_W-1:0] divisor;
	fpDivPkg::quotField quot;
	logic sticky;
	fpDivPkg::divJob jobReg;

	// per cycle step results
	logic bitHi;
	logic bitLo;
	logic [REM_W-1:0] remMid;
	logic [REM_W-1:0] remNext;

	assign lastIter = (iter == CNT_W'(`DIV_ITERS - 1));

	// ---------------------------------------------------------------------------
	// two restoring steps per clock
	// ---------------------------------------------------------------------------

	always_comb begin
		// first bit of the pair
		bitHi = (rem >= divisor);
		remMid = (bitHi ? rem - divisor : rem) << 1;
		// second bit works on the shifted partial remainder
		bitLo = (remMid >= divisor);
		remNext = (bitLo ? remMid - divisor : remMid) << 1;
	end

	// ---------------------------------------------------------------------------
	// control
	// ---------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= fpDivPkg::IDLE;
			iter <= '0;
			resValid <= 1'b0;
		end else if (ce) begin
			resValid <= 1'b0;
			case (state)
				fpDivPkg::IDLE: begin
					if (jobValid) begin
						state <= fpDivPkg::RUN;
						iter <= '0;
					end
				end
				fpDivPkg::RUN: begin
					iter <= iter + 1'b1;
					// quotient complete after the last pair
					if (lastIter) begin
						state <= fpDivPkg::IDLE;
						resValid <= 1'b1;
					end
				end
				default: state <= fpDivPkg::IDLE;
			endcase
		end
	end

	// ---------------------------------------------------------------------------
	// datapath
	// ---------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (ce) begin
			if (state == fpDivPkg::IDLE && jobValid) begin
				// dividend significand is the first partial remainder
				rem <= {2'b00, job.dividend.mant};
				divisor <= {2'b00, job.divisor.mant};
				quot <= '0;
				jobReg <= job;
			end else if (state == fpDivPkg::RUN) begin
				rem <= remNext;
				// msb first, first bit lands on top after all pairs
				quot <= {quot[`QUOT_W-3:0], bitHi, bitLo};
				// anything left over feeds rounding
				if (lastIter)
					sticky <= |remNext;
			end
		end
	end

	assign res = '{quot: quot, sticky: sticky, job: jobReg};

endmodule

/* fpDivPkg.sv */
`include "fpDiv_consts.svh"

package fpDivPkg;

	// whole packed float
	typedef logic [`FP_WORD_W-1:0] fpWord;
	// biased exponent as stored
	typedef logic [`FP_EXP_W-1:0] expField;
	// significand with the hidden bit in front
	typedef logic [`FP_FRAC_W:0] mantField;
	// unbiased difference, two spare bits for sign and range
	typedef logic signed [`FP_EXP_W+1:0] expDiffField;
	// raw quotient from the core, integer bit on top
	typedef logic [`QUOT_W-1:0] quotField;

	// one decoded operand
	typedef struct packed {
		logic sign;
		expField exp;
		mantField mant;
		logic isZero;
		logic isInf;
		logic isNan;
	} fpClass;

	// both operands of one divide
	typedef struct packed {
		fpClass dividend;
		fpClass divisor;
	} divJob;

	// core output, the job rides along with its quotient
	typedef struct packed {
		quotField quot;
		logic sticky;
		divJob job;
	} coreResult;

	// mantissa divider FSM
	typedef enum logic {
		IDLE,
		RUN
	} coreState;

endpackage

/* fpDivRound.sv */
`timescale 1ns/1ps
`include "fpDiv_consts.svh"

module fpDivRound (
	input  logic clk,
	input  logic rst,
	input  logic ce,
	input  logic resValid,
	input  fpDivPkg::coreResult res,
	input  logic busy,
	output fpDivPkg::fpWord o,
	output logic done,
	output logic overflow,
	output logic underflow,
	output logic divByZero,
	output logic invalid
);

	localparam int SIG_W = `FP_FRAC_W + 1;
	localparam int EXP_MAX = (1 << `FP_EXP_W) - 1;
	// canonical quiet NaN, positive
	localparam fpDivPkg::fpWord QNAN =
		{1'b0, {`FP_EXP_W{1'b1}}, 1'b1, {(`FP_FRAC_W-1){1'b0}}};

	// stage one inputs
	fpDivPkg::fpClass opA;
	fpDivPkg::fpClass opB;
	logic nanCase;
	logic infCase;
	logic zeroCase;
	logic dbzCase;
	fpDivPkg::expDiffField expRaw;

	// stage one registers
	logic s1Valid;
	logic s1Sign;
	logic s1Nan;
	logic s1Inf;
	logic s1Zero;
	logic s1DivZero;
	fpDivPkg::expDiffField s1Exp;
	fpDivPkg::quotField s1Quot;
	logic s1Sticky;

	// stage two
	fpDivPkg::quotField normQ;
	fpDivPkg::mantField sig;
	logic guard;
	logic rest;
	logic roundUp;
	logic [SIG_W:0] sum;
	logic carry;
	logic [`FP_FRAC_W-1:0] frac;
	fpDivPkg::expDiffField expFinal;
	fpDivPkg::fpWord infWord;
	fpDivPkg::fpWord zeroWord;

	assign opA = res.job.dividend;
	assign opB = res.job.divisor;

	// ---------------------------------------------------------------------------
	// stage one, exponent and special case select
	// ---------------------------------------------------------------------------

	always_comb begin
		// any NaN, 0/0 and inf/inf all give the invalid result
		nanCase = opA.isNan | opB.isNan | (opA.isZero & opB.isZero) | (opA.isInf & opB.isInf);
		infCase = 1'b0;
		zeroCase = 1'b0;
		dbzCase = 1'b0;
		if (!nanCase) begin
			if (opA.isInf)
				infCase = 1'b1;
			else if (opB.isInf)
				zeroCase = 1'b1;
			else if (opB.isZero) begin
				infCase = 1'b1;
				dbzCase = 1'b1;
			end else if (opA.isZero)
				zeroCase = 1'b1;
		end
		expRaw = fpDivPkg::expDiffField'({2'b00, opA.exp})
			- fpDivPkg::expDiffField'({2'b00, opB.exp})
			+ fpDivPkg::expDiffField'(`FP_BIAS);
		// quotient below one, normalizing shifts left once
		if (!res.quot[`QUOT_W-1])
			expRaw = expRaw - fpDivPkg::expDiffField'(1);
	end

	always_ff @(posedge clk) begin
		if (rst)
			s1Valid <= 1'b0;
		else if (ce)
			s1Valid <= resValid;
	end

	always_ff @(posedge clk) begin
		if (ce && resValid) begin
			s1Sign <= opA.sign ^ opB.sign;
			s1Nan <= nanCase;
			s1Inf <= infCase;
			s1Zero <= zeroCase;
			s1DivZero <= dbzCase;
			s1Exp <= expRaw;
			s1Quot <= res.quot;
			s1Sticky <= res.sticky;
		end
	end

	// ---------------------------------------------------------------------------
	// stage two, normalize, round to nearest even, pack
	// ---------------------------------------------------------------------------

	always_comb begin
		normQ = s1Quot[`QUOT_W-1] ? s1Quot : s1Quot << 1;
		sig = normQ[`QUOT_W-1 -: SIG_W];
		guard = normQ[`QUOT_W-1-SIG_W];
		// round, spare and core remainder fold into one sticky
		rest = |normQ[`QUOT_W-2-SIG_W:0] | s1Sticky;
		// ties go to the even significand
		roundUp = guard & (rest | sig[0]);
		sum = {1'b0, sig} + (SIG_W+1)'(roundUp);
		// all ones rounded up, significand becomes 1.0 one binade higher
		carry = sum[SIG_W];
		frac = carry ? sum[SIG_W-1:1] : sum[SIG_W-2:0];
		expFinal = s1Exp + fpDivPkg::expDiffField'(carry);
		infWord = {s1Sign, {`FP_EXP_W{1'b1}}, {`FP_FRAC_W{1'b0}}};
		zeroWord = {s1Sign, {(`FP_WORD_W-1){1'b0}}};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			o <= '0;
			done <= 1'b1;
			overflow <= 1'b0;
			underflow <= 1'b0;
			divByZero <= 1'b0;
			invalid <= 1'b0;
		end else if (ce) begin
			if (s1Valid) begin
				done <= 1'b1;
				invalid <= s1Nan;
				divByZero <= s1DivZero;
				overflow <= 1'b0;
				underflow <= 1'b0;
				if (s1Nan)
					o <= QNAN;
				else if (s1Inf)
					o <= infWord;
				else if (s1Zero)
					o <= zeroWord;
				else if (expFinal >= EXP_MAX) begin
					// out of range on the rounded exponent
					o <= infWord;
					overflow <= 1'b1;
				end else if (expFinal <= 0) begin
					// no denormal output, flush
					o <= zeroWord;
					underflow <= 1'b1;
				end else
					o <= {s1Sign, expFinal[`FP_EXP_W-1:0], frac};
			end else if (busy)
				done <= 1'b0;
		end
	end

endmodule

/* fpDiv_consts.svh */
`ifndef FPDIV_CONSTS_SVH
`define FPDIV_CONSTS_SVH

// ---------------------------------------------------------------------------
// binary32 format
// ---------------------------------------------------------------------------

// biased exponent field
`define FP_EXP_W 8
// stored fraction, hidden bit not counted
`define FP_FRAC_W 23
// exponent of 1.0
`define FP_BIAS 127
// whole packed word
`define FP_WORD_W 32

// ---------------------------------------------------------------------------
// mantissa divider
// ---------------------------------------------------------------------------

// integer bit, 24 significand bits, guard, round and one spare
`define QUOT_W 28
// radix-4 core retires two quotient bits per cycle
`define DIV_ITERS 14

`endif

/* fpDivide.f */
+incdir+.
fpDivPkg.sv
fpDecompose.sv
fpDivCore.sv
fpDivRound.sv
fpDivide.sv
fpDivide_checker.sv
tbClock.sv
tb_fpDivide.sv

/* fpDivide.sv */
`timescale 1ns/1ps

module fpDivide (
	input  logic clk,
	input  logic rst,
	input  logic ce,
	input  logic ld,
	input  fpDivPkg::fpWord a,
	input  fpDivPkg::fpWord b,
	output fpDivPkg::fpWord o,
	output logic done,
	output logic overflow,
	output logic underflow,
	output logic divByZero,
	output logic invalid
);

	// decode to core
	logic jobValid;
	fpDivPkg::divJob job;
	// core to round
	logic resValid;
	fpDivPkg::coreResult res;
	// op accepted but done not yet dropped
	logic busy;

	fpDecompose prod0 (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.ld(ld),
		.a(a),
		.b(b),
		.done(done),
		.jobValid(jobValid),
		.job(job),
		.busy(busy)
	);

	fpDivCore core0 (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.jobValid(jobValid),
		.job(job),
		.resValid(resValid),
		.res(res)
	);

	fpDivRound cons0 (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.resValid(resValid),
		.res(res),
		.busy(busy),
		.o(o),
		.done(done),
		.overflow(overflow),
		.underflow(underflow),
		.divByZero(divByZero),
		.invalid(invalid)
	);

endmodule

/* fpDivide_checker.sv */
`timescale 1ns/1ps

module fpDivide_checker (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic ld,
	input logic done,
	input logic busy,
	input logic overflow,
	input logic divByZero,
	input logic invalid
);

	// ce-high edges seen since the last accepted ld
	int ceCount;
	logic accepted;

	assign accepted = ce && ld && done && !busy;

	always_ff @(posedge clk) begin
		if (rst)
			ceCount <= 0;
		else if (accepted)
			ceCount <= 0;
		else if (ce && (busy || !done))
			ceCount <= ceCount + 1;
	end

	// ------------------------------------------------------------------------
	// rules
	// ------------------------------------------------------------------------

	// done drops on the first enabled edge after an accepted ld
	assert property (@(posedge clk) disable iff (rst) $fell(done) |-> ceCount == 1)
		else $error("done fell without an accepted ld");

	// pipeline depth counted in enabled cycles
	assert property (@(posedge clk) disable iff (rst) $rose(done) |-> ceCount == 17)
		else $error("done rose after %0d enabled cycles", ceCount);

	// at most one of the exclusive flags
	assert property (@(posedge clk) disable iff (rst)
		$onehot0({invalid, divByZero, overflow}))
		else $error("exclusive flags set together");

	assert property (@(posedge clk) $fell(rst) |-> done)
		else $error("done low after reset");

endmodule

bind fpDivide fpDivide_checker chk0 (
	.clk(clk),
	.rst(rst),
	.ce(ce),
	.ld(ld),
	.done(done),
	.busy(busy),
	.overflow(overflow),
	.divByZero(divByZero),
	.invalid(invalid)
);

/* tbClock.sv */
`timescale 1ns/1ps

module tbClock (
	output logic clk,
	output logic rst
);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// reset held over the first 4 rising edges
	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

/* tb_fpDivide.sv */
`timescale 1ns/1ps
`include "fpDiv_consts.svh"

module tb_fpDivide;

	localparam int N_DIR = 20;
	localparam int N_RANDOM = 40;
	localparam int N_STALL = 12;
	localparam int N_TESTS = N_DIR + N_RANDOM + 1;
	// each stall lasts at most 8 cycles
	localparam int CE_LOW_MAX = N_STALL * 8;
	// latency is the core iterations plus three register stages, four cycles of slack
	localparam int LIMIT = N_TESTS * (`DIV_ITERS + 3 + 4) + CE_LOW_MAX + 100;

	// dividend in the upper half, divisor in the lower
	localparam logic [63:0] DIRECTED [N_DIR] = '{
		64'h40C00000_40400000, 64'h3F800000_40400000, 64'h3F800000_3F800000,
		64'h3FFFFFFF_3F800001, 64'hC0E00000_40000000, 64'h41200000_BDCCCCCD,
		64'h00000000_00000000, 64'h7F800000_FF800000, 64'h3F800000_00000000,
		64'hBF800000_00000000, 64'h3F800000_7F800000, 64'hC0000000_7F800000,
		64'hFF800000_40000000, 64'h7FC00001_3F800000, 64'h3F800000_FFA00000,
		64'h7F000000_00800000, 64'h00800000_7F000000, 64'h00000001_3F800000,
		64'h3F800000_00000005, 64'h80000000_40400000
	};

	logic clk;
	logic rst;
	logic ce;
	logic ld;
	fpDivPkg::fpWord a;
	fpDivPkg::fpWord b;
	fpDivPkg::fpWord o;
	logic done;
	logic overflow;
	logic underflow;
	logic divByZero;
	logic invalid;

	integer seed;
	int cycles;
	logic prevDone;
	// expected {o, overflow, underflow, divByZero, invalid} per op
	logic [35:0] expQ[$];

	tbClock clkGen0 (.clk(clk), .rst(rst));

	fpDivide dut0 (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.ld(ld),
		.a(a),
		.b(b),
		.o(o),
		.done(done),
		.overflow(overflow),
		.underflow(underflow),
		.divByZero(divByZero),
		.invalid(invalid)
	);

	task automatic reportMismatch(input string name, input logic [31:0] expV,
		input logic [31:0] actV);
		$display("CHECK FAILED %s expected %h got %h", name, expV, actV);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic reportProblem(input string what);
		$display("%s", what);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------

	function automatic logic [35:0] refDivide(input logic [31:0] x, input logic [31:0] y);
		int ex;
		int ey;
		int e;
		int sh;
		longint ma;
		longint mb;
		longint q;
		longint r;
		longint sig;
		logic zx;
		logic zy;
		logic ix;
		logic iy;
		logic nx;
		logic ny;
		logic s;
		logic g;
		logic st;
		logic [31:0] res;
		logic ovf;
		logic unf;
		logic dbz;
		logic inv;
		ex = {24'b0, x[30:23]};
		ey = {24'b0, y[30:23]};
		zx = (ex == 0);
		zy = (ey == 0);
		ix = (ex == 255) && (x[22:0] == 23'b0);
		iy = (ey == 255) && (y[22:0] == 23'b0);
		nx = (ex == 255) && (x[22:0] != 23'b0);
		ny = (ey == 255) && (y[22:0] != 23'b0);
		s = x[31] ^ y[31];
		ovf = 1'b0;
		unf = 1'b0;
		dbz = 1'b0;
		inv = 1'b0;
		if (nx || ny || (zx && zy) || (ix && iy)) begin
			res = 32'h7FC00000;
			inv = 1'b1;
		end else if (ix)
			res = {s, 8'hFF, 23'b0};
		else if (iy)
			res = {s, 31'b0};
		else if (zy) begin
			res = {s, 8'hFF, 23'b0};
			dbz = 1'b1;
		end else if (zx)
			res = {s, 31'b0};
		else begin
			ma = {40'b0, 1'b1, x[22:0]};
			mb = {40'b0, 1'b1, y[22:0]};
			// quotient in [2^31, 2^33)
			q = (ma << 32) / mb;
			r = (ma << 32) % mb;
			e = ex - ey + 127;
			if (q >= (64'sd1 << 32))
				sh = 9;
			else begin
				sh = 8;
				e = e - 1;
			end
			sig = q >> sh;
			g = q[sh-1];
			st = ((q & ((64'sd1 << (sh - 1)) - 1)) != 0) || (r != 0);
			if (g && (st || sig[0]))
				sig = sig + 1;
			// rounding ran past the top bit
			if (sig == (64'sd1 << 24)) begin
				sig = sig >> 1;
				e = e + 1;
			end
			if (e >= 255) begin
				res = {s, 8'hFF, 23'b0};
				ovf = 1'b1;
			end else if (e <= 0) begin
				res = {s, 31'b0};
				unf = 1'b1;
			end else
				res = {s, e[7:0], sig[22:0]};
		end
		return {res, ovf, unf, dbz, inv};
	endfunction

	// ------------------------------------------------------------------------
	// compare on each rise of done
	// ------------------------------------------------------------------------

	always @(negedge clk) begin
		logic [35:0] expV;
		if (rst)
			prevDone = 1'b1;
		else begin
			if (done && !prevDone) begin
				if (expQ.size() == 0)
					reportProblem("done rose with no operation outstanding");
				else begin
					expV = expQ.pop_front();
					assert (o === expV[35:4]) else reportMismatch("o", expV[35:4], o);
					assert (overflow === expV[3])
						else reportMismatch("overflow", {31'b0, expV[3]}, {31'b0, overflow});
					assert (underflow === expV[2])
						else reportMismatch("underflow", {31'b0, expV[2]}, {31'b0, underflow});
					assert (divByZero === expV[1])
						else reportMismatch("divByZero", {31'b0, expV[1]}, {31'b0, divByZero});
					assert (invalid === expV[0])
						else reportMismatch("invalid", {31'b0, expV[0]}, {31'b0, invalid});
				end
			end
			prevDone = done;
		end
	end

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT)
			reportProblem("timeout, the run took more cycles than the tests need");
	end

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------

	// one divide, optional ld held through the run and optional ce stall
	task automatic runOp(input logic [31:0] x, input logic [31:0] y, input bit stall,
		input bit extraLd);
		int ceHigh;
		int edges;
		int stallLen;
		int stallLeft;
		while (!done)
			@(negedge clk);
		@(posedge clk);
		a <= x;
		b <= y;
		ld <= 1'b1;
		ce <= 1'b1;
		expQ.push_back(refDivide(x, y));
		// accept edge
		@(posedge clk);
		if (extraLd) begin
			a <= ~x;
			b <= y ^ 32'h1;
		end else
			ld <= 1'b0;
		ceHigh = 0;
		edges = 0;
		stallLen = 0;
		stallLeft = 0;
		do begin
			@(posedge clk);
			edges++;
			if (ce)
				ceHigh++;
			// a held ld is let go one edge before done may rise
			if (!extraLd || edges >= 16)
				ld <= 1'b0;
			if (stall && edges == 6) begin
				stallLen = 1 + ($random(seed) & 7);
				stallLeft = stallLen;
			end
			if (stallLeft > 0) begin
				ce <= 1'b0;
				stallLeft--;
			end else
				ce <= 1'b1;
			@(negedge clk);
			if (edges == 1)
				assert (done == 1'b0) else reportProblem("done did not fall after ld");
		end while (!done);
		assert (edges == 17 + stallLen)
			else reportMismatch("stalled latency", 17 + stallLen, edges);
		assert (ceHigh == 17) else reportMismatch("latency", 32'd17, ceHigh);
	endtask

	function automatic logic [31:0] randomNormal();
		logic [31:0] w;
		int e;
		w = $random(seed);
		// exponents near the middle keep most quotients normal
		e = 64 + ($random(seed) & 127);
		w[30:23] = e[7:0];
		return w;
	endfunction

	initial begin
		logic [31:0] x;
		logic [31:0] y;
		seed = 32'he120;
		cycles = 0;
		ce = 1'b1;
		ld = 1'b0;
		a = '0;
		b = '0;
		@(negedge clk);
		while (rst)
			@(negedge clk);
		for (int i = 0; i < N_DIR; i++)
			runOp(DIRECTED[i][63:32], DIRECTED[i][31:0], 1'b0, 1'b0);
		// ld held high while the op runs must be ignored
		runOp(32'h40C00000, 32'h40400000, 1'b0, 1'b1);
		for (int i = 0; i < N_RANDOM; i++) begin
			x = randomNormal();
			y = randomNormal();
			runOp(x, y, i >= N_RANDOM - N_STALL, 1'b0);
		end
		// let the compare process see the last result
		@(posedge clk);
		@(negedge clk);
		if (expQ.size() != 0) begin
			$display("results missing at end of run");
			$display("=== FAIL ===");
			$fatal(1);
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule
